// File: Makefile
# Verilator build of the instruction cache testbench

TOP := icache_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module $(TOP) -f list.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

// File: list.f
rtl/icache_pkg.sv
rtl/icache_req_buf.sv
rtl/icache_tag_lru.sv
rtl/icache_data_array.sv
rtl/icache_ctrl.sv
rtl/icache_fetch_out.sv
rtl/icache_top.sv
verification/tb_clk_gen.sv
verification/icache_mem_model.sv
verification/icache_tb.sv

// File: rtl/icache_ctrl.sv
// state machine for lookup, miss, refill, cache operations, flush and stall
`timescale 1ns/1ns
`default_nettype none

module icache_ctrl import icache_pkg::*; (
    input  wire              clk,
    input  wire              rst,
    input  wire              req_valid,
    output logic             req_ready,
    input  wire              stall,
    input  wire              flush,
    input  wire              buf_is_op,
    input  wire cache_op_e   buf_op,
    input  wire [WAYS-1:0]   hit,
    input  wire              victim,
    output logic             buf_load,
    output logic             arr_wr_en,
    output logic             arr_wr_way,
    output logic             use_en,
    output logic             use_way,
    output logic [WAYS-1:0]  inv_mask,
    output logic             inv_all,
    output logic             sel_return,
    output logic             sel_way,
    output logic             out_valid,
    output logic             mem_req,
    input  wire              mem_addr_ok,
    input  wire              mem_data_ok
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic        drop_q;
    logic        hit_any;
    logic        live_lookup;
    logic        fetch_hit;
    logic        line_back;

    assign hit_any     = |hit;
    // flush kills whatever sits in lookup
    assign live_lookup = (state_q == S_LOOKUP) && !flush;
    assign fetch_hit   = live_lookup && !buf_is_op && hit_any;
    assign line_back   = (state_q == S_REFILL) && mem_data_ok;

    ////////////////////
    // request side
    ////////////////////

    // a hit that is consumed now frees the buffer for the next request
    assign req_ready = !stall && ((state_q == S_IDLE) || fetch_hit);
    assign buf_load  = req_valid && req_ready;

    ////////////////////
    // array and output control
    ////////////////////

    assign out_valid  = fetch_hit || (line_back && !drop_q && !flush);
    assign mem_req    = (state_q == S_MISS);
    assign arr_wr_en  = line_back;
    assign arr_wr_way = victim;
    assign use_en     = fetch_hit || line_back;
    assign use_way    = line_back ? victim : hit[1];
    assign sel_return = (state_q == S_REFILL);
    assign sel_way    = hit[1];

    // cache op decode applied in lookup
    always_comb begin
        inv_mask = '0;
        inv_all  = 1'b0;
        if (live_lookup && buf_is_op) begin
            case (buf_op)
                OP_INIT:    inv_all  = 1'b1;
                OP_IDX_INV: inv_mask = '1;
                OP_HIT_INV: inv_mask = hit;
                default:    inv_mask = '0;
            endcase
        end
    end

    ////////////////////
    // state machine
    ////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (buf_load) state_d = S_LOOKUP;
            end
            S_LOOKUP: begin
                if (flush || buf_is_op) state_d = S_IDLE;
                else if (!hit_any) state_d = S_MISS;
                else if (!buf_load) state_d = S_IDLE;
            end
            S_MISS: begin
                if (mem_addr_ok) state_d = S_REFILL;
            end
            S_REFILL: begin
                if (mem_data_ok) state_d = S_IDLE;
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) state_q <= S_IDLE;
        else state_q <= state_d;
    end

    // line still fills after a flush but the result is dropped
    always_ff @(posedge clk) begin
        if (rst) begin
            drop_q <= 1'b0;
        end else if (state_q == S_LOOKUP) begin
            drop_q <= 1'b0;
        end else if (flush && ((state_q == S_MISS) || (state_q == S_REFILL))) begin
            drop_q <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/icache_data_array.sv
// two banks of line storage with synchronous read and whole-line write
`timescale 1ns/1ns
`default_nettype none

module icache_data_array import icache_pkg::*; (
    input  wire                clk,
    input  wire [INDEX_W-1:0]  rd_index,
    output logic [LINE_W-1:0]  rd_line0,
    output logic [LINE_W-1:0]  rd_line1,
    input  wire [INDEX_W-1:0]  wr_index,
    input  wire                wr_way,
    input  wire                wr_en,
    input  wire [LINE_W-1:0]   wr_line
);

    ////////////////////
    // line banks
    ////////////////////

    logic [LINE_W-1:0] bank0 [SETS];
    logic [LINE_W-1:0] bank1 [SETS];

    // refill writes one way only
    always_ff @(posedge clk) begin
        if (wr_en && !wr_way) begin
            bank0[wr_index] <= wr_line;
        end
        if (wr_en && wr_way) begin
            bank1[wr_index] <= wr_line;
        end
    end

    // both ways read every cycle and picked later
    always_ff @(posedge clk) begin
        rd_line0 <= bank0[rd_index];
        rd_line1 <= bank1[rd_index];
    end

endmodule

`default_nettype wire

// File: rtl/icache_fetch_out.sv
// output side with line and way select, word pair forming and stall hold register
`timescale 1ns/1ns
`default_nettype none

module icache_fetch_out import icache_pkg::*; (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 stall,
    input  wire                 out_valid_in,
    input  wire                 sel_return,
    input  wire                 sel_way,
    input  wire [LINE_W-1:0]    rd_line0,
    input  wire [LINE_W-1:0]    rd_line1,
    input  wire [LINE_W-1:0]    mem_line,
    input  wire [OFFSET_W-1:0]  buf_offset,
    input  wire [31:0]          buf_pc,
    output logic                out_valid,
    output logic [63:0]         out_insn,
    output logic                out_pair,
    output logic [31:0]         out_pc
);

    logic [LINE_W-1:0]   line;
    logic [OFFSET_W-1:0] hi_offset;
    logic [31:0]         word_lo;
    logic [31:0]         word_hi;
    logic                pair_flag;
    logic [63:0]         pair_insn;
    logic                hold_valid_q;
    logic                hold_pair_q;
    logic [63:0]         hold_insn_q;
    logic [31:0]         hold_pc_q;

    // returning line bypasses the arrays
    assign line      = sel_return ? mem_line : (sel_way ? rd_line1 : rd_line0);
    assign hi_offset = {buf_offset[OFFSET_W-1:1], 1'b1};
    assign word_lo   = line[32*buf_offset +: 32];
    assign word_hi   = line[32*hi_offset +: 32];

    // second slot only valid inside the aligned pair
    assign pair_flag = !buf_offset[0];
    assign pair_insn = pair_flag ? {word_hi, word_lo} : {NOP_INSN, word_lo};

    ////////////////////
    // stall hold
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst || !stall) begin
            hold_valid_q <= 1'b0;
        end else if (!hold_valid_q) begin
            hold_valid_q <= out_valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (stall && !hold_valid_q) begin
            hold_insn_q <= pair_insn;
            hold_pair_q <= pair_flag;
            hold_pc_q   <= buf_pc;
        end
    end

    assign out_valid = hold_valid_q || out_valid_in;
    assign out_insn  = hold_valid_q ? hold_insn_q : pair_insn;
    assign out_pair  = hold_valid_q ? hold_pair_q : pair_flag;
    assign out_pc    = hold_valid_q ? hold_pc_q : buf_pc;

endmodule

`default_nettype wire

// File: rtl/icache_pkg.sv
// icache geometry constants, nop word, cache operation and controller state enums
`default_nettype none

package icache_pkg;

    ////////////////////
    // geometry
    ////////////////////

    // 16 sets of 4-word lines, two ways
    localparam int INDEX_W  = 4;
    localparam int OFFSET_W = 2;
    localparam int WAYS     = 2;
    localparam int SETS     = 1 << INDEX_W;

    // address split of a byte address
    localparam int INDEX_LSB = OFFSET_W + 2;
    localparam int TAG_LSB   = INDEX_LSB + INDEX_W;
    localparam int TAG_W     = 32 - TAG_LSB;

    localparam int LINE_W = 32 << OFFSET_W;

    // filler for the upper slot when the pair is split
    localparam logic [31:0] NOP_INSN = 32'h03400000;

    ////////////////////
    // encodings
    ////////////////////

    typedef enum logic [1:0] {
        OP_INIT    = 2'd0,
        OP_IDX_INV = 2'd1,
        OP_HIT_INV = 2'd2
    } cache_op_e;

    typedef enum logic [1:0] {
        S_IDLE   = 2'd0,
        S_LOOKUP = 2'd1,
        S_MISS   = 2'd2,
        S_REFILL = 2'd3
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: rtl/icache_req_buf.sv
// request buffer with tag, index and word offset split
`timescale 1ns/1ns
`default_nettype none

module icache_req_buf import icache_pkg::*; (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  load,
    input  wire                  flush,
    input  wire [31:0]           req_addr,
    input  wire                  req_is_op,
    input  wire cache_op_e       req_op,
    output logic [TAG_W-1:0]     buf_tag,
    output logic [INDEX_W-1:0]   buf_index,
    output logic [OFFSET_W-1:0]  buf_offset,
    output logic                 buf_is_op,
    output cache_op_e            buf_op,
    output logic [31:0]          buf_pc
);

    // kind of the buffered item
    always_ff @(posedge clk) begin
        if (rst) begin
            buf_is_op <= 1'b0;
        end else if (load) begin
            buf_is_op <= req_is_op;
        end
    end

    // address fields held through miss and stall
    always_ff @(posedge clk) begin
        if (load) begin
            buf_tag    <= req_addr[31:TAG_LSB];
            buf_index  <= req_addr[TAG_LSB-1:INDEX_LSB];
            buf_offset <= req_addr[INDEX_LSB-1:2];
            buf_op     <= req_op;
            buf_pc     <= req_addr;
        end
    end

endmodule

`default_nettype wire

// File: rtl/icache_tag_lru.sv
// tag and valid storage, hit compare, per-set lru bit and victim choice
`timescale 1ns/1ns
`default_nettype none

module icache_tag_lru import icache_pkg::*; (
    input  wire                 clk,
    input  wire                 rst,
    input  wire [INDEX_W-1:0]   rd_index,
    input  wire [TAG_W-1:0]     cmp_tag,
    output logic [WAYS-1:0]     hit,
    output logic                victim,
    input  wire [INDEX_W-1:0]   wr_index,
    input  wire                 wr_way,
    input  wire                 wr_en,
    input  wire                 use_en,
    input  wire                 use_way,
    input  wire [INDEX_W-1:0]   inv_index,
    input  wire [WAYS-1:0]      inv_mask,
    input  wire                 inv_all
);

    logic [TAG_W-1:0] tag_mem [WAYS][SETS];
    logic [SETS-1:0]  valid_q [WAYS];
    logic [SETS-1:0]  lru_q;
    logic [TAG_W-1:0] rd_tag [WAYS];
    logic [WAYS-1:0]  rd_valid;

    // tag store written with the buffered tag on refill
    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (wr_en && (wr_way == w[0])) tag_mem[w][wr_index] <= cmp_tag;
            rd_tag[w] <= tag_mem[w][rd_index];
        end
    end

    // valid bits, init clears all of them in one cycle
    always_ff @(posedge clk) begin
        if (rst || inv_all) begin
            for (int w = 0; w < WAYS; w++) valid_q[w] <= '0;
        end else begin
            for (int w = 0; w < WAYS; w++) begin
                if (inv_mask[w]) valid_q[w][inv_index] <= 1'b0;
                if (wr_en && (wr_way == w[0])) valid_q[w][wr_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= '0;
        end else begin
            for (int w = 0; w < WAYS; w++) rd_valid[w] <= valid_q[w][rd_index];
        end
    end

    // lru bit names the way to replace next
    always_ff @(posedge clk) begin
        if (rst) begin
            lru_q <= '0;
        end else if (use_en) begin
            lru_q[wr_index] <= ~use_way;
        end
    end

    always_comb begin
        for (int w = 0; w < WAYS; w++) hit[w] = rd_valid[w] && (rd_tag[w] == cmp_tag);
    end

    // empty way first, then lru
    assign victim = !valid_q[0][wr_index] ? 1'b0 :
                    !valid_q[1][wr_index] ? 1'b1 : lru_q[wr_index];

endmodule

`default_nettype wire

// File: rtl/icache_top.sv
// two-way instruction cache top level with request buffer, arrays, ctrl and output side
`timescale 1ns/1ns
`default_nettype none

module icache_top import icache_pkg::*; (
    input  wire                clk,
    input  wire                rst,
    input  wire                req_valid,
    input  wire [31:0]         req_addr,
    input  wire                req_is_op,
    input  wire cache_op_e     req_op,
    output logic               req_ready,
    input  wire                stall,
    input  wire                flush,
    output logic               out_valid,
    output logic [31:0]        out_pc,
    output logic [63:0]        out_insn,
    output logic               out_pair,
    output logic               mem_req,
    output logic [31:0]        mem_addr,
    input  wire                mem_addr_ok,
    input  wire                mem_data_ok,
    input  wire [LINE_W-1:0]   mem_line
);

    logic [TAG_W-1:0]    buf_tag;
    logic [INDEX_W-1:0]  buf_index;
    logic [OFFSET_W-1:0] buf_offset;
    logic                buf_is_op;
    cache_op_e           buf_op;
    logic [31:0]         buf_pc;
    logic [WAYS-1:0]     hit;
    logic                victim;
    logic                buf_load;
    logic                arr_wr_en;
    logic                arr_wr_way;
    logic                use_en;
    logic                use_way;
    logic [WAYS-1:0]     inv_mask;
    logic                inv_all;
    logic                sel_return;
    logic                sel_way;
    logic                ctrl_valid;
    logic [LINE_W-1:0]   rd_line0;
    logic [LINE_W-1:0]   rd_line1;

    // line-aligned refill address
    assign mem_addr = {buf_tag, buf_index, {INDEX_LSB{1'b0}}};

    icache_req_buf u_req_buf (
        .clk(clk), .rst(rst), .load(buf_load), .flush(flush),
        .req_addr(req_addr), .req_is_op(req_is_op), .req_op(req_op),
        .buf_tag(buf_tag), .buf_index(buf_index), .buf_offset(buf_offset),
        .buf_is_op(buf_is_op), .buf_op(buf_op), .buf_pc(buf_pc)
    );

    // arrays are read with the index of the incoming address
    icache_tag_lru u_tag_lru (
        .clk(clk), .rst(rst), .rd_index(req_addr[TAG_LSB-1:INDEX_LSB]),
        .cmp_tag(buf_tag), .hit(hit), .victim(victim),
        .wr_index(buf_index), .wr_way(arr_wr_way), .wr_en(arr_wr_en),
        .use_en(use_en), .use_way(use_way),
        .inv_index(buf_index), .inv_mask(inv_mask), .inv_all(inv_all)
    );

    icache_data_array u_data_array (
        .clk(clk), .rd_index(req_addr[TAG_LSB-1:INDEX_LSB]),
        .rd_line0(rd_line0), .rd_line1(rd_line1),
        .wr_index(buf_index), .wr_way(arr_wr_way), .wr_en(arr_wr_en), .wr_line(mem_line)
    );

    icache_ctrl u_ctrl (
        .clk(clk), .rst(rst), .req_valid(req_valid), .req_ready(req_ready),
        .stall(stall), .flush(flush), .buf_is_op(buf_is_op), .buf_op(buf_op),
        .hit(hit), .victim(victim), .buf_load(buf_load),
        .arr_wr_en(arr_wr_en), .arr_wr_way(arr_wr_way), .use_en(use_en), .use_way(use_way),
        .inv_mask(inv_mask), .inv_all(inv_all), .sel_return(sel_return), .sel_way(sel_way),
        .out_valid(ctrl_valid), .mem_req(mem_req),
        .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok)
    );

    icache_fetch_out u_fetch_out (
        .clk(clk), .rst(rst), .stall(stall), .out_valid_in(ctrl_valid),
        .sel_return(sel_return), .sel_way(sel_way),
        .rd_line0(rd_line0), .rd_line1(rd_line1), .mem_line(mem_line),
        .buf_offset(buf_offset), .buf_pc(buf_pc),
        .out_valid(out_valid), .out_insn(out_insn), .out_pair(out_pair), .out_pc(out_pc)
    );

endmodule

`default_nettype wire

// File: verification/icache_mem_model.sv
// line memory responder with random address and data latency
`timescale 1ns/1ns
`default_nettype none

module icache_mem_model import icache_pkg::*; (
    input  wire               clk,
    input  wire               rst,
    input  wire               mem_req,
    input  wire [31:0]        mem_addr,
    output logic              mem_addr_ok,
    output logic              mem_data_ok,
    output logic [LINE_W-1:0] mem_line
);

    integer      seed;
    int          delay;
    logic [31:0] line_addr;

    // each word holds its own byte address xor a fixed pattern
    function automatic logic [LINE_W-1:0] fill_line(input logic [31:0] base);
        logic [LINE_W-1:0] l;
        for (int i = 0; i < (1 << OFFSET_W); i++) begin
            l[32*i +: 32] = (base + 32'(i * 4)) ^ 32'h5a5a0000;
        end
        return l;
    endfunction

    initial begin
        seed        = 32'hf181d572;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_line    = '0;
        forever begin
            @(negedge clk);
            if (!rst && mem_req) begin
                // address phase of 0 to 3 cycles
                delay = int'($unsigned($random(seed)) % 4);
                repeat (delay) @(negedge clk);
                line_addr   = mem_addr;
                mem_addr_ok = 1'b1;
                @(negedge clk);
                mem_addr_ok = 1'b0;
                // data phase 1 to 4 cycles later
                delay = int'($unsigned($random(seed)) % 4);
                repeat (delay) @(negedge clk);
                mem_line    = fill_line(line_addr);
                mem_data_ok = 1'b1;
                @(negedge clk);
                mem_data_ok = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/icache_tb.sv
// testbench top with stimulus table, reference tag and lru model, compare tasks and timeouts
`timescale 1ns/1ns
`default_nettype none

module icache_tb import icache_pkg::*;;

    logic clk;
    logic rst;
    logic req_valid;
    logic req_is_op;
    logic stall;
    logic flush;
    logic req_ready;
    logic out_valid;
    logic out_pair;
    logic mem_req;
    logic mem_addr_ok;
    logic mem_data_ok;
    logic [31:0] req_addr;
    logic [31:0] out_pc;
    logic [31:0] mem_addr;
    logic [31:0] last_mem_addr;
    logic [63:0] out_insn;
    logic [LINE_W-1:0] mem_line;
    cache_op_e req_op;
    int handshakes;

    // stimulus table
    logic [31:0] t_addr [$];
    logic        t_is_op [$];
    cache_op_e   t_op [$];
    int          t_stall [$];
    logic        t_flush [$];

    // reference model of the tag side
    logic [TAG_W-1:0] m_tag [2][SETS];
    logic             m_valid [2][SETS];
    logic             m_lru [SETS];

    tb_clk_gen u_clk (.clk(clk));

    icache_top uut (
        .clk(clk), .rst(rst), .req_valid(req_valid), .req_addr(req_addr),
        .req_is_op(req_is_op), .req_op(req_op), .req_ready(req_ready),
        .stall(stall), .flush(flush), .out_valid(out_valid), .out_pc(out_pc),
        .out_insn(out_insn), .out_pair(out_pair), .mem_req(mem_req), .mem_addr(mem_addr),
        .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok), .mem_line(mem_line)
    );

    icache_mem_model u_mem (
        .clk(clk), .rst(rst), .mem_req(mem_req), .mem_addr(mem_addr),
        .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok), .mem_line(mem_line)
    );

    always @(posedge clk) begin
        if (!rst && mem_req && mem_addr_ok) begin
            handshakes    = handshakes + 1;
            last_mem_addr = mem_addr;
        end
    end

    task automatic report_fail(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            report_fail($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_fail($sformatf("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_miss(input int exp, input logic [31:0] addr);
        check_word("memory transfers", 32'(handshakes), 32'(exp));
        if (exp > 0) check_word("mem_addr", last_mem_addr, addr & 32'hffff_fff0);
    endtask

    function automatic logic [31:0] expect_word(input logic [31:0] a);
        return a ^ 32'h5a5a0000;
    endfunction

    function automatic int model_hit_way(input logic [31:0] addr);
        int idx;
        idx = int'(addr[TAG_LSB-1:INDEX_LSB]);
        for (int w = 0; w < 2; w++) begin
            if (m_valid[w][idx] && m_tag[w][idx] == addr[31:TAG_LSB]) return w;
        end
        return -1;
    endfunction

    // samples are taken 1 ns after the falling edge
    task automatic send_request(input logic [31:0] addr, input logic is_op, input cache_op_e op);
        int n;
        n = 0;
        @(negedge clk);
        req_valid = 1'b1;
        req_addr  = addr;
        req_is_op = is_op;
        req_op    = op;
        #1;
        while (!req_ready) begin
            n = n + 1;
            if (n >= 200) report_fail("timeout waiting for req_ready");
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic wait_out_valid(output int cycles);
        cycles = 1;
        #1;
        while (!out_valid) begin
            cycles = cycles + 1;
            if (cycles >= 200) report_fail("timeout waiting for out_valid");
            @(negedge clk);
            #1;
        end
    endtask

    task automatic wait_mem_req();
        int n;
        n = 0;
        #1;
        while (!mem_req) begin
            n = n + 1;
            if (n >= 200) report_fail("timeout waiting for mem_req");
            check_flag("out_valid", out_valid, 1'b0);
            @(negedge clk);
            #1;
        end
    endtask

    // idle again after the dropped refill with no result shown
    task automatic wait_ready_quiet();
        int n;
        n = 0;
        #1;
        while (!req_ready) begin
            n = n + 1;
            if (n >= 200) report_fail("timeout waiting for req_ready after flush");
            check_flag("out_valid", out_valid, 1'b0);
            @(negedge clk);
            #1;
        end
        check_flag("out_valid", out_valid, 1'b0);
    endtask

    task automatic check_result(input logic [31:0] addr);
        logic [31:0] base;
        base = addr & 32'hffff_fffc;
        check_word("out_insn[31:0]", out_insn[31:0], expect_word(base));
        if (!addr[2]) begin
            check_word("out_insn[63:32]", out_insn[63:32], expect_word(base + 32'd4));
        end else begin
            check_word("out_insn[63:32]", out_insn[63:32], NOP_INSN);
        end
        check_flag("out_pair", out_pair, !addr[2]);
        check_word("out_pc", out_pc, addr);
    endtask

    task automatic model_fill(input logic [31:0] addr);
        int idx;
        int v;
        idx = int'(addr[TAG_LSB-1:INDEX_LSB]);
        if (!m_valid[0][idx]) v = 0;
        else if (!m_valid[1][idx]) v = 1;
        else v = int'(m_lru[idx]);
        m_valid[v][idx] = 1'b1;
        m_tag[v][idx]   = addr[31:TAG_LSB];
        m_lru[idx]      = (v == 0);
    endtask

    task automatic run_entry(input logic [31:0] addr, input logic is_op, input cache_op_e op,
                             input int stall_len, input logic flush_en);
        int way;
        int idx;
        int cycles;
        logic [63:0] held_insn;
        logic [31:0] held_pc;
        logic held_pair;
        idx = int'(addr[TAG_LSB-1:INDEX_LSB]);
        way = model_hit_way(addr);
        handshakes = 0;
        send_request(addr, is_op, op);
        if (is_op) begin
            #1;
            check_flag("out_valid", out_valid, 1'b0);
            if (op == OP_INIT) begin
                for (int s = 0; s < SETS; s++) begin
                    m_valid[0][s] = 1'b0;
                    m_valid[1][s] = 1'b0;
                end
            end else if (op == OP_IDX_INV) begin
                m_valid[0][idx] = 1'b0;
                m_valid[1][idx] = 1'b0;
            end else if (way >= 0) begin
                m_valid[way][idx] = 1'b0;
            end
            check_miss(0, addr);
        end else if (flush_en) begin
            wait_mem_req();
            @(negedge clk);
            flush = 1'b1;
            #1;
            check_flag("out_valid", out_valid, 1'b0);
            @(negedge clk);
            flush = 1'b0;
            wait_ready_quiet();
            model_fill(addr);
            check_miss(1, addr);
        end else begin
            if (stall_len > 0) stall = 1'b1;
            wait_out_valid(cycles);
            if (way >= 0) check_word("hit latency", 32'(cycles), 32'd1);
            check_result(addr);
            if (stall_len > 0) begin
                held_insn = out_insn;
                held_pc   = out_pc;
                held_pair = out_pair;
                repeat (stall_len) begin
                    @(negedge clk);
                    #1;
                    check_flag("out_valid", out_valid, 1'b1);
                    check_flag("req_ready", req_ready, 1'b0);
                    check_word("held out_insn[31:0]", out_insn[31:0], held_insn[31:0]);
                    check_word("held out_insn[63:32]", out_insn[63:32], held_insn[63:32]);
                    check_word("held out_pc", out_pc, held_pc);
                    check_flag("held out_pair", out_pair, held_pair);
                end
                @(negedge clk);
                stall = 1'b0;
                #1;
                check_flag("out_valid", out_valid, 1'b1);
            end
            // result consumed exactly once
            @(negedge clk);
            #1;
            check_flag("out_valid after consume", out_valid, 1'b0);
            if (way >= 0) m_lru[idx] = (way == 0);
            else model_fill(addr);
            check_miss((way >= 0) ? 0 : 1, addr);
        end
    endtask

    task automatic add_entry(input logic [31:0] a, input logic is_op, input cache_op_e op,
                             input int stall_len, input logic flush_en);
        t_addr.push_back(a);
        t_is_op.push_back(is_op);
        t_op.push_back(op);
        t_stall.push_back(stall_len);
        t_flush.push_back(flush_en);
    endtask

    initial begin
        rst = 1'b1;
        req_valid = 1'b0;
        req_addr = '0;
        req_is_op = 1'b0;
        req_op = OP_INIT;
        stall = 1'b0;
        flush = 1'b0;
        handshakes = 0;
        last_mem_addr = '0;
        for (int s = 0; s < SETS; s++) begin
            m_valid[0][s] = 1'b0;
            m_valid[1][s] = 1'b0;
            m_lru[s] = 1'b0;
        end
        ////////////////////
        // address, op flag, op, stall cycles, flush
        add_entry(32'h0000_1030, 1'b0, OP_INIT, 0, 1'b0);
        add_entry(32'h0000_1034, 1'b0, OP_INIT, 0, 1'b0);
        add_entry(32'h0000_1038, 1'b0, OP_INIT, 0, 1'b0);
        add_entry(32'h0000_2030, 1'b0, OP_INIT, 0, 1'b0);
        add_entry(32'h0000_103c, 1'b0, OP_INIT, 0, 1'b0);
        add_entry(32'h0000_3030, 1'b0, OP_INIT, 0, 1'b0);
        add_entry(32'h0000_2034, 1'b0, OP_INIT, 0, 1'b0);
        add_entry(32'h0000_3030, 1'b0, OP_INIT, 0, 1'b0);
        add_entry(32'h0000_3030, 1'b1, OP_HIT_INV, 0, 1'b0);
        add_entry(32'h0000_3030, 1'b0, OP_INIT, 0, 1'b0);
        add_entry(32'h0000_2030, 1'b0, OP_INIT, 0, 1'b0);
        add_entry(32'h0000_1050, 1'b0, OP_INIT, 0, 1'b0);
        add_entry(32'h0000_3030, 1'b1, OP_IDX_INV, 0, 1'b0);
        add_entry(32'h0000_2034, 1'b0, OP_INIT, 0, 1'b0);
        add_entry(32'h0000_1054, 1'b0, OP_INIT, 0, 1'b0);
        add_entry(32'h0000_0000, 1'b1, OP_INIT, 0, 1'b0);
        add_entry(32'h0000_1050, 1'b0, OP_INIT, 0, 1'b0);
        add_entry(32'h0000_1058, 1'b0, OP_INIT, 3, 1'b0);
        add_entry(32'h0000_4074, 1'b0, OP_INIT, 2, 1'b0);
        add_entry(32'h0000_5080, 1'b0, OP_INIT, 0, 1'b1);
        add_entry(32'h0000_5084, 1'b0, OP_INIT, 0, 1'b0);
        add_entry(32'h0000_6098, 1'b0, OP_INIT, 1, 1'b0);
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < t_addr.size(); i++) begin
            run_entry(t_addr[i], t_is_op[i], t_op[i], t_stall[i], t_flush[i]);
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/tb_clk_gen.sv
// free running testbench clock with a 4 ns period
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

endmodule

`default_nettype wire
